//--- Bender.yml
package:
  name: rename_unit

sources:
  - hdl/rename_tag_pkg.sv
  - hdl/rename_cfg_pkg.sv
  - hdl/free_list.sv
  - hdl/map_table.sv
  - hdl/checkpoint_store.sv
  - hdl/rename_control.sv
  - hdl/rename_unit.sv
  - target: test
    files:
      - verification/rename_unit_tb.sv

//--- build.f
hdl/rename_tag_pkg.sv
hdl/rename_cfg_pkg.sv
hdl/free_list.sv
hdl/map_table.sv
hdl/checkpoint_store.sv
hdl/rename_control.sv
hdl/rename_unit.sv
verification/rename_unit_tb.sv

//--- hdl/checkpoint_store.sv
`default_nettype none

module checkpoint_store
	import rename_cfg_pkg::*;
#(
	parameter int NUM_CHECKPOINTS = DEFAULT_CHECKPOINTS,
	parameter type payload_t = logic
) (
	input wire logic clock,
	input wire logic reset,
	// snapshot at branch dispatch
	input wire logic push,
	// oldest branch resolved correctly
	input wire logic pop,
	// mispredict flushes every pending snapshot
	input wire logic clear,
	input wire payload_t push_data,
	output payload_t oldest_data,
	output logic full
);

	localparam int PTR_W = (NUM_CHECKPOINTS > 1) ? $clog2(NUM_CHECKPOINTS) : 1;
	localparam int CNT_W = $clog2(NUM_CHECKPOINTS + 1);

	payload_t slots [NUM_CHECKPOINTS];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(NUM_CHECKPOINTS - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// branches resolve in order, so the oldest is always the one wanted
	assign oldest_data = slots[rd_ptr];
	assign full = (count == CNT_W'(NUM_CHECKPOINTS));

	always_ff @(posedge clock) begin
		if (push) begin
			slots[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset || clear) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	assert property (@(posedge clock) disable iff (reset) push |-> !full);

	// a pop or flush with nothing stored means a resolve without a branch
	assert property (@(posedge clock) disable iff (reset) pop || clear |-> count != '0);

endmodule

`default_nettype wire

//--- hdl/free_list.sv
`default_nettype none

module free_list
	import rename_tag_pkg::*, rename_cfg_pkg::*;
#(
	parameter int NUM_ARCH_REGS = DEFAULT_ARCH_REGS,
	parameter int NUM_PHYS_REGS = DEFAULT_PHYS_REGS
) (
	input wire logic clock,
	input wire logic reset,
	// retire push of a released tag
	input wire logic enable,
	input wire phys_tag_t t_old,
	// dispatch pop of a new destination tag
	input wire logic dispatch_en,
	// mispredict restore of the head
	input wire logic branch_incorrect,
	input wire logic [$clog2(NUM_PHYS_REGS)-1:0] head_check_point,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] head_out,
	output logic [$clog2(NUM_PHYS_REGS+1)-1:0] num_free_entries,
	output logic empty,
	output phys_tag_t free_reg
);

	// tags not mapped at reset, the most that can ever be free
	localparam int FREE_MAX = NUM_PHYS_REGS - NUM_ARCH_REGS;
	localparam int PTR_W = $clog2(NUM_PHYS_REGS);
	localparam int CNT_W = $clog2(NUM_PHYS_REGS + 1);

	// one slot per physical tag, so head == tail only when empty
	phys_tag_t ring [NUM_PHYS_REGS];
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [PTR_W-1:0] tail_nxt;
	logic [CNT_W-1:0] count;
	logic full;

	// pointer step with wrap at the ring size
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(NUM_PHYS_REGS - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// entries from one pointer up to another, going round the ring
	function automatic logic [CNT_W-1:0] ring_dist(input logic [PTR_W-1:0] from_ptr,
			input logic [PTR_W-1:0] to_ptr);
		if (to_ptr >= from_ptr) begin
			return CNT_W'(to_ptr) - CNT_W'(from_ptr);
		end
		return CNT_W'(NUM_PHYS_REGS) - CNT_W'(from_ptr) + CNT_W'(to_ptr);
	endfunction

	// tail after this cycle's retire, also used by the restore count
	assign tail_nxt = enable ? ptr_inc(tail) : tail;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(FREE_MAX));
	assign free_reg = ring[head];
	assign head_out = head;
	assign num_free_entries = count;

	// reset fills the ring with the tags above the identity mapping
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < FREE_MAX; i++) begin
				ring[i] <= phys_tag_t'(NUM_ARCH_REGS + i);
			end
		end else if (enable) begin
			ring[tail] <= t_old;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= PTR_W'(FREE_MAX);
			count <= CNT_W'(FREE_MAX);
		end else begin
			// retire always lands, restore or not
			tail <= tail_nxt;
			if (branch_incorrect) begin
				// tags popped after the branch come back, retired ones stay
				head <= head_check_point;
				count <= ring_dist(head_check_point, tail_nxt);
			end else begin
				if (dispatch_en) begin
					head <= ptr_inc(head);
				end
				case ({enable, dispatch_en})
					2'b10: count <= count + 1'b1;
					2'b01: count <= count - 1'b1;
					default: count <= count;
				endcase
			end
		end
	end

	// a retire beyond the free capacity means a tag was freed twice
	assert property (@(posedge clock) disable iff (reset)
		enable && !dispatch_en && !branch_incorrect |-> !full);

	assert property (@(posedge clock) disable iff (reset) dispatch_en |-> !empty);

	assert property (@(posedge clock)
		NUM_PHYS_REGS <= MAX_PHYS_REGS && NUM_ARCH_REGS < NUM_PHYS_REGS);

endmodule

`default_nettype wire

//--- hdl/map_table.sv
`default_nettype none

module map_table
	import rename_tag_pkg::*, rename_cfg_pkg::*;
#(
	parameter int NUM_ARCH_REGS = DEFAULT_ARCH_REGS
) (
	input wire logic clock,
	input wire logic reset,
	input wire arch_tag_t src1_arch,
	input wire arch_tag_t src2_arch,
	input wire arch_tag_t dest_arch,
	// new mapping for dest_arch
	input wire logic write_en,
	input wire phys_tag_t write_phys,
	// whole-table reload from a branch snapshot
	input wire logic restore_en,
	input wire phys_tag_t [NUM_ARCH_REGS-1:0] restore_map,
	output phys_tag_t src1_phys,
	output phys_tag_t src2_phys,
	output phys_tag_t dest_old_phys,
	output phys_tag_t [NUM_ARCH_REGS-1:0] map_out
);

	// one physical tag per architectural register
	phys_tag_t [NUM_ARCH_REGS-1:0] map_q;

	// reads come from the registered table
	// so a source equal to this cycle's dest sees the old tag
	assign src1_phys = map_q[src1_arch];
	assign src2_phys = map_q[src2_arch];

	// previous mapping goes to the ROB to be freed at retire
	assign dest_old_phys = map_q[dest_arch];

	// snapshot source for the checkpoint store
	assign map_out = map_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			// identity mapping, register i lives in tag i
			for (int i = 0; i < NUM_ARCH_REGS; i++) begin
				map_q[i] <= phys_tag_t'(i);
			end
		end else if (restore_en) begin
			map_q <= restore_map;
		end else if (write_en) begin
			map_q[dest_arch] <= write_phys;
		end
	end

	// the arch tag field is wider than the table
	assert property (@(posedge clock) disable iff (reset)
		src1_arch < NUM_ARCH_REGS && src2_arch < NUM_ARCH_REGS);

	assert property (@(posedge clock) disable iff (reset)
		write_en |-> dest_arch < NUM_ARCH_REGS && NUM_ARCH_REGS <= MAX_ARCH_REGS);

endmodule

`default_nettype wire

//--- hdl/rename_cfg_pkg.sv
`default_nettype none

package rename_cfg_pkg;

	// architectural registers seen by software
	localparam int DEFAULT_ARCH_REGS = 32;

	// physical registers behind the map table
	localparam int DEFAULT_PHYS_REGS = 64;

	// branches that may be in flight at once
	localparam int DEFAULT_CHECKPOINTS = 4;

endpackage

`default_nettype wire

//--- hdl/rename_control.sv
`default_nettype none

module rename_control
	import rename_cfg_pkg::*;
#(
	parameter int NUM_CHECKPOINTS = DEFAULT_CHECKPOINTS
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic dispatch_valid,
	input wire logic dispatch_is_branch,
	input wire logic dispatch_dest_valid,
	input wire logic branch_resolve,
	input wire logic branch_mispredict,
	// resource state from the datapath
	input wire logic free_empty,
	input wire logic checkpoint_full,
	output logic stall,
	output logic alloc_en,
	output logic map_write_en,
	output logic take_checkpoint,
	output logic restore_en,
	output logic pop_checkpoint
);

	localparam int CNT_W = $clog2(NUM_CHECKPOINTS + 1);

	// branches dispatched and not yet resolved
	logic [CNT_W-1:0] pending;
	logic mispredict;
	logic dispatch_go;

	assign mispredict = branch_resolve && branch_mispredict;

	// hold dispatch when out of tags, out of checkpoints, or flushing
	assign stall = dispatch_valid &&
		((dispatch_dest_valid && free_empty) ||
		(dispatch_is_branch && checkpoint_full) ||
		mispredict);

	assign dispatch_go = dispatch_valid && !stall;

	// dest tag pop and map update move together
	assign alloc_en = dispatch_go && dispatch_dest_valid;
	assign map_write_en = dispatch_go && dispatch_dest_valid;
	assign take_checkpoint = dispatch_go && dispatch_is_branch;

	// resolve splits into restore or plain pop
	assign restore_en = mispredict;
	assign pop_checkpoint = branch_resolve && !branch_mispredict;

	always_ff @(posedge clock) begin
		if (reset || restore_en) begin
			// a mispredict squashes every younger branch too
			pending <= '0;
		end else begin
			pending <= pending + CNT_W'(take_checkpoint) - CNT_W'(pop_checkpoint);
		end
	end

	assert property (@(posedge clock) disable iff (reset) !(restore_en && take_checkpoint));

	assert property (@(posedge clock) disable iff (reset) branch_resolve |-> pending != '0);

endmodule

`default_nettype wire

//--- hdl/rename_tag_pkg.sv
`default_nettype none

package rename_tag_pkg;

	// largest physical register file a tag can address
	localparam int MAX_PHYS_REGS = 256;

	// largest architectural register file a tag can address
	localparam int MAX_ARCH_REGS = 64;

	// physical register tag, handed out by the free list
	typedef logic [$clog2(MAX_PHYS_REGS)-1:0] phys_tag_t;

	// architectural register tag, as named by the instruction
	typedef logic [$clog2(MAX_ARCH_REGS)-1:0] arch_tag_t;

endpackage

`default_nettype wire

//--- hdl/rename_unit.sv
`default_nettype none

module rename_unit
	import rename_tag_pkg::*, rename_cfg_pkg::*;
#(
	parameter int NUM_ARCH_REGS = DEFAULT_ARCH_REGS,
	parameter int NUM_PHYS_REGS = DEFAULT_PHYS_REGS,
	parameter int NUM_CHECKPOINTS = DEFAULT_CHECKPOINTS
) (
	input wire logic clock,
	input wire logic reset,
	// dispatch side, held while stall is high
	input wire logic dispatch_valid,
	input wire logic dispatch_is_branch,
	input wire logic dispatch_dest_valid,
	input wire arch_tag_t dispatch_dest_arch,
	input wire arch_tag_t dispatch_src1_arch,
	input wire arch_tag_t dispatch_src2_arch,
	// retire side from the ROB
	input wire logic retire_en,
	input wire phys_tag_t retire_old_phys,
	// branch outcome, oldest first
	input wire logic branch_resolve,
	input wire logic branch_mispredict,
	output logic stall,
	output phys_tag_t src1_phys,
	output phys_tag_t src2_phys,
	output phys_tag_t dest_phys,
	output phys_tag_t dest_old_phys,
	output logic [$clog2(NUM_PHYS_REGS+1)-1:0] num_free
);

	localparam int HEAD_W = $clog2(NUM_PHYS_REGS);

	// the two snapshot payloads
	typedef phys_tag_t [NUM_ARCH_REGS-1:0] map_snap_t;
	typedef logic [HEAD_W-1:0] head_snap_t;

	logic alloc_en;
	logic map_write_en;
	logic take_checkpoint;
	logic restore_en;
	logic pop_checkpoint;
	logic free_empty;
	logic map_ckpt_full;
	logic head_ckpt_full;
	head_snap_t head_now;
	head_snap_t head_restore;
	map_snap_t map_now;
	map_snap_t map_restore;

	rename_control #(
		.NUM_CHECKPOINTS(NUM_CHECKPOINTS)
	) control (
		.clock(clock), .reset(reset),
		.dispatch_valid(dispatch_valid), .dispatch_is_branch(dispatch_is_branch),
		.dispatch_dest_valid(dispatch_dest_valid),
		.branch_resolve(branch_resolve), .branch_mispredict(branch_mispredict),
		.free_empty(free_empty), .checkpoint_full(map_ckpt_full | head_ckpt_full),
		.stall(stall), .alloc_en(alloc_en), .map_write_en(map_write_en),
		.take_checkpoint(take_checkpoint), .restore_en(restore_en),
		.pop_checkpoint(pop_checkpoint)
	);

	// dest_phys is the tag at the free-list head
	free_list #(
		.NUM_ARCH_REGS(NUM_ARCH_REGS), .NUM_PHYS_REGS(NUM_PHYS_REGS)
	) free_tags (
		.clock(clock), .reset(reset),
		.enable(retire_en), .t_old(retire_old_phys), .dispatch_en(alloc_en),
		.branch_incorrect(restore_en), .head_check_point(head_restore),
		.head_out(head_now), .num_free_entries(num_free), .empty(free_empty),
		.free_reg(dest_phys)
	);

	map_table #(
		.NUM_ARCH_REGS(NUM_ARCH_REGS)
	) map (
		.clock(clock), .reset(reset),
		.src1_arch(dispatch_src1_arch), .src2_arch(dispatch_src2_arch),
		.dest_arch(dispatch_dest_arch),
		.write_en(map_write_en), .write_phys(dest_phys),
		.restore_en(restore_en), .restore_map(map_restore),
		.src1_phys(src1_phys), .src2_phys(src2_phys),
		.dest_old_phys(dest_old_phys), .map_out(map_now)
	);

	// a branch writes no dest, so the current table is the snapshot
	checkpoint_store #(
		.NUM_CHECKPOINTS(NUM_CHECKPOINTS), .payload_t(map_snap_t)
	) map_ckpt (
		.clock(clock), .reset(reset),
		.push(take_checkpoint), .pop(pop_checkpoint), .clear(restore_en),
		.push_data(map_now), .oldest_data(map_restore), .full(map_ckpt_full)
	);

	// likewise the head does not move on a branch
	checkpoint_store #(
		.NUM_CHECKPOINTS(NUM_CHECKPOINTS), .payload_t(head_snap_t)
	) head_ckpt (
		.clock(clock), .reset(reset),
		.push(take_checkpoint), .pop(pop_checkpoint), .clear(restore_en),
		.push_data(head_now), .oldest_data(head_restore), .full(head_ckpt_full)
	);

endmodule

`default_nettype wire

//--- verification/rename_input.txt
# inputs: valid branch dest_valid dest_arch src1_arch src2_arch retire retire_tag resolve mispredict
# expected: stall src1_phys src2_phys dest_phys dest_old_phys num_free (all hex)
1 0 1 01 02 03 0 00 0 0  0 02 03 20 01 20
1 0 1 04 01 01 0 00 0 0  0 20 20 21 04 1f
1 0 1 01 01 04 0 00 0 0  0 20 21 22 20 1e
1 0 1 05 01 00 1 01 0 0  0 22 00 23 05 1d
0 0 0 00 05 04 1 20 0 0  0 23 21 24 00 1d
1 1 0 00 05 01 0 00 0 0  0 23 22 24 00 1e
1 0 1 01 05 04 0 00 0 0  0 23 21 24 22 1e
1 0 1 02 01 00 1 05 0 0  0 24 00 25 02 1d
1 0 1 05 02 02 0 00 0 0  0 25 25 26 23 1d
1 0 1 06 01 05 1 04 1 1  1 24 26 27 06 1c
1 0 1 06 01 05 0 00 0 0  0 22 23 24 06 20
1 1 0 00 06 02 0 00 0 0  0 24 02 25 00 1f
1 0 1 02 06 00 0 00 0 0  0 24 00 25 02 1f
0 0 0 00 02 06 0 00 1 0  0 25 24 26 00 1e
1 1 0 00 01 02 0 00 0 0  0 22 25 26 00 1e
1 1 0 00 01 02 0 00 0 0  0 22 25 26 00 1e
1 1 0 00 01 02 0 00 0 0  0 22 25 26 00 1e
1 1 0 00 01 02 0 00 0 0  0 22 25 26 00 1e
1 1 0 00 01 02 0 00 0 0  1 22 25 26 00 1e
1 1 0 00 01 02 0 00 1 0  1 22 25 26 00 1e
1 1 0 00 01 02 0 00 0 0  0 22 25 26 00 1e
1 0 1 07 07 00 0 00 0 0  0 07 00 26 07 1e
1 0 1 07 07 00 0 00 0 0  0 26 00 27 26 1d
1 0 1 07 07 00 0 00 0 0  0 27 00 28 27 1c
1 0 1 07 07 00 0 00 0 0  0 28 00 29 28 1b
1 0 1 07 07 00 0 00 0 0  0 29 00 2a 29 1a
1 0 1 07 07 00 0 00 0 0  0 2a 00 2b 2a 19
1 0 1 07 07 00 0 00 0 0  0 2b 00 2c 2b 18
1 0 1 07 07 00 0 00 0 0  0 2c 00 2d 2c 17
1 0 1 07 07 00 0 00 0 0  0 2d 00 2e 2d 16
1 0 1 07 07 00 0 00 0 0  0 2e 00 2f 2e 15
1 0 1 07 07 00 0 00 0 0  0 2f 00 30 2f 14
1 0 1 07 07 00 0 00 0 0  0 30 00 31 30 13
1 0 1 07 07 00 0 00 0 0  0 31 00 32 31 12
1 0 1 07 07 00 0 00 0 0  0 32 00 33 32 11
1 0 1 07 07 00 0 00 0 0  0 33 00 34 33 10
1 0 1 07 07 00 0 00 0 0  0 34 00 35 34 0f
1 0 1 07 07 00 0 00 0 0  0 35 00 36 35 0e
1 0 1 07 07 00 0 00 0 0  0 36 00 37 36 0d
1 0 1 07 07 00 0 00 0 0  0 37 00 38 37 0c
1 0 1 07 07 00 0 00 0 0  0 38 00 39 38 0b
1 0 1 07 07 00 0 00 0 0  0 39 00 3a 39 0a
1 0 1 07 07 00 0 00 0 0  0 3a 00 3b 3a 09
1 0 1 07 07 00 0 00 0 0  0 3b 00 3c 3b 08
1 0 1 07 07 00 0 00 0 0  0 3c 00 3d 3c 07
1 0 1 07 07 00 0 00 0 0  0 3d 00 3e 3d 06
1 0 1 07 07 00 0 00 0 0  0 3e 00 3f 3e 05
1 0 1 07 07 00 0 00 0 0  0 3f 00 01 3f 04
1 0 1 07 07 00 0 00 0 0  0 01 00 20 01 03
1 0 1 07 07 00 0 00 0 0  0 20 00 05 20 02
1 0 1 07 07 00 0 00 0 0  0 05 00 04 05 01
1 0 1 07 07 00 0 00 0 0  1 04 00 00 04 00
1 0 1 07 07 00 1 07 0 0  1 04 00 00 04 00
1 0 1 07 07 00 0 00 0 0  0 04 00 07 04 01
1 0 0 00 07 01 0 00 0 0  0 07 22 00 00 00

//--- verification/rename_unit_tb.sv
`default_nettype none

module rename_unit_tb
	import rename_tag_pkg::*, rename_cfg_pkg::*;
;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_VECTORS = 256;
	localparam int NUM_FIELDS = 16;
	localparam string VECTOR_FILE = "verification/rename_input.txt";

	// column positions in one line of the vector file
	localparam int F_VALID = 0;
	localparam int F_BRANCH = 1;
	localparam int F_DEST_VALID = 2;
	localparam int F_DEST = 3;
	localparam int F_SRC1 = 4;
	localparam int F_SRC2 = 5;
	localparam int F_RETIRE = 6;
	localparam int F_RETIRE_TAG = 7;
	localparam int F_RESOLVE = 8;
	localparam int F_MISPREDICT = 9;
	localparam int F_STALL = 10;
	localparam int F_SRC1_PHYS = 11;
	localparam int F_SRC2_PHYS = 12;
	localparam int F_DEST_PHYS = 13;
	localparam int F_DEST_OLD = 14;
	localparam int F_NUM_FREE = 15;

	logic clock;
	logic reset;
	logic dispatch_valid;
	logic dispatch_is_branch;
	logic dispatch_dest_valid;
	arch_tag_t dispatch_dest_arch;
	arch_tag_t dispatch_src1_arch;
	arch_tag_t dispatch_src2_arch;
	logic retire_en;
	phys_tag_t retire_old_phys;
	logic branch_resolve;
	logic branch_mispredict;
	logic stall;
	phys_tag_t src1_phys;
	phys_tag_t src2_phys;
	phys_tag_t dest_phys;
	phys_tag_t dest_old_phys;
	logic [$clog2(DEFAULT_PHYS_REGS+1)-1:0] num_free;

	// one row per cycle, inputs then expected outputs
	logic [7:0] vectors [MAX_VECTORS][NUM_FIELDS];
	logic [7:0] fld [NUM_FIELDS];
	int num_vectors = 0;
	int file_lines = 0;
	logic vectors_loaded = 1'b0;

	rename_unit uut (
		.clock(clock), .reset(reset),
		.dispatch_valid(dispatch_valid), .dispatch_is_branch(dispatch_is_branch),
		.dispatch_dest_valid(dispatch_dest_valid), .dispatch_dest_arch(dispatch_dest_arch),
		.dispatch_src1_arch(dispatch_src1_arch), .dispatch_src2_arch(dispatch_src2_arch),
		.retire_en(retire_en), .retire_old_phys(retire_old_phys),
		.branch_resolve(branch_resolve), .branch_mispredict(branch_mispredict),
		.stall(stall), .src1_phys(src1_phys), .src2_phys(src2_phys),
		.dest_phys(dest_phys), .dest_old_phys(dest_old_phys), .num_free(num_free)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	task abort_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task load_vectors();
		int fd;
		int n_read;
		string line;
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0) begin
			abort_run({"could not open vector file ", VECTOR_FILE});
		end
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0) begin
				break;
			end
			file_lines++;
			// comment and empty lines carry no cycle
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			n_read = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
				fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15]);
			if (n_read != NUM_FIELDS) begin
				abort_run($sformatf("line %0d of the vector file is malformed", file_lines));
			end
			if (num_vectors >= MAX_VECTORS) begin
				abort_run("vector file holds more cycles than the testbench can store");
			end
			for (int k = 0; k < NUM_FIELDS; k++) begin
				vectors[num_vectors][k] = fld[k];
			end
			num_vectors++;
		end
		$fclose(fd);
		vectors_loaded = 1'b1;
	endtask

	// called right after a rising edge
	task apply_vector(input int idx);
		dispatch_valid <= (vectors[idx][F_VALID] != 8'h00);
		dispatch_is_branch <= (vectors[idx][F_BRANCH] != 8'h00);
		dispatch_dest_valid <= (vectors[idx][F_DEST_VALID] != 8'h00);
		dispatch_dest_arch <= arch_tag_t'(vectors[idx][F_DEST]);
		dispatch_src1_arch <= arch_tag_t'(vectors[idx][F_SRC1]);
		dispatch_src2_arch <= arch_tag_t'(vectors[idx][F_SRC2]);
		retire_en <= (vectors[idx][F_RETIRE] != 8'h00);
		retire_old_phys <= vectors[idx][F_RETIRE_TAG];
		branch_resolve <= (vectors[idx][F_RESOLVE] != 8'h00);
		branch_mispredict <= (vectors[idx][F_MISPREDICT] != 8'h00);
	endtask

	task check_field(input string name, input logic [7:0] got, input logic [7:0] expected,
			input int idx);
		assert (got === expected) else begin
			abort_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h in cycle %0d",
				$time, name, got, expected, idx));
		end
	endtask

	task check_outputs(input int idx);
		check_field("stall", stall, vectors[idx][F_STALL], idx);
		check_field("src1_phys", src1_phys, vectors[idx][F_SRC1_PHYS], idx);
		check_field("src2_phys", src2_phys, vectors[idx][F_SRC2_PHYS], idx);
		// an empty list has only a stale tag at its head
		if (vectors[idx][F_NUM_FREE] != 8'h00) begin
			check_field("dest_phys", dest_phys, vectors[idx][F_DEST_PHYS], idx);
		end
		check_field("dest_old_phys", dest_old_phys, vectors[idx][F_DEST_OLD], idx);
		check_field("num_free", num_free, vectors[idx][F_NUM_FREE], idx);
	endtask

	// limit scales with the length of the vector file
	initial begin
		wait (vectors_loaded);
		#(2 * (file_lines + 20) * CLK_PERIOD);
		abort_run("timeout, the vector run did not finish in time");
	end

	initial begin
		reset = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_is_branch = 1'b0;
		dispatch_dest_valid = 1'b0;
		dispatch_dest_arch = '0;
		dispatch_src1_arch = '0;
		dispatch_src2_arch = '0;
		retire_en = 1'b0;
		retire_old_phys = '0;
		branch_resolve = 1'b0;
		branch_mispredict = 1'b0;
		load_vectors();
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		// drive on the rising edge, rename is combinational so check on the falling one
		for (int i = 0; i < num_vectors; i++) begin
			apply_vector(i);
			@(negedge clock);
			check_outputs(i);
			@(posedge clock);
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
